// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= div_unit_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh testbench/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)
PASS    := *** TEST PASSED ***

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '$(PASS)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/div_arbiter.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`DIV_PORTS-1:0] pending,
    input  div_pkg::div_req_t     held_req [`DIV_PORTS],
    output logic [`DIV_PORTS-1:0] grant,
    input  logic                  ready,
    output logic                  load,
    output div_pkg::div_req_t     core_req,
    input  logic                  finish,
    input  div_pkg::div_rsp_t     core_rsp,
    output logic [`DIV_PORTS-1:0] complete,
    output div_pkg::div_rsp_t     complete_rsp
);

    localparam int idx_w = (`DIV_PORTS > 1) ? $clog2(`DIV_PORTS) : 1;

    logic [idx_w-1:0] ptr;   // port with top priority
    logic [idx_w-1:0] owner; // port whose request is in the core
    logic [idx_w-1:0] sel;
    logic             found;

    // first pending port at or after ptr
    always_comb begin
        int unsigned cand;
        found = 1'b0;
        sel   = ptr;
        for (int i = 0; i < `DIV_PORTS; i++) begin
            cand = (int'(ptr) + i) % `DIV_PORTS;
            if (!found && pending[cand]) begin
                found = 1'b1;
                sel   = idx_w'(cand);
            end
        end
    end

    assign load     = ready && found;
    assign core_req = held_req[sel];

    always_comb begin
        grant = '0;
        if (load) grant[sel] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr      <= '0;
            owner    <= '0;
            complete <= '0;
        end else begin
            complete <= '0;
            if (load) begin
                owner <= sel;
                ptr   <= (sel == idx_w'(`DIV_PORTS - 1)) ? '0 : sel + 1'b1; // served port goes last
            end
            if (finish) complete[owner] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) complete_rsp <= core_rsp;
    end

endmodule

// File: design/div_core.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  div_pkg::div_req_t req,
    output logic              ready,
    output logic              finish,
    output div_pkg::div_rsp_t rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_prepare,
        st_divide,
        st_complete
    } state_t;

    localparam int unsigned last_step = `DIV_XLEN - 1;
    localparam logic [`DIV_XLEN-1:0] min_neg = {1'b1, {(`DIV_XLEN - 1){1'b0}}};

    state_t                state;
    logic [`DIV_CNT_W-1:0] cnt;

    div_pkg::div_req_t     req_q;  // request under work
    logic [`DIV_XLEN-1:0]  rem;
    logic [`DIV_XLEN-1:0]  quo;
    logic [`DIV_XLEN-1:0]  den;
    logic                  sign_q;
    logic                  sign_r;
    logic                  div_zero;
    logic                  overflow;

    logic                  is_signed;
    logic                  dividend_neg;
    logic                  divisor_neg;
    logic [`DIV_XLEN:0]    rem_shift; // one bit wider than the data
    logic [`DIV_XLEN-1:0]  quo_signed;
    logic [`DIV_XLEN-1:0]  rem_signed;
    logic [`DIV_XLEN-1:0]  result;

    assign is_signed    = (req_q.op == div_pkg::op_div) || (req_q.op == div_pkg::op_rem);
    assign dividend_neg = is_signed && req_q.dividend[`DIV_XLEN-1];
    assign divisor_neg  = is_signed && req_q.divisor[`DIV_XLEN-1];
    assign rem_shift    = {rem, quo[`DIV_XLEN-1]};

    assign ready  = (state == st_idle);
    assign finish = (state == st_complete);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (load) state <= st_prepare;
                end
                st_prepare: begin
                    state <= st_divide;
                    cnt   <= '0;
                end
                st_divide: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == last_step[`DIV_CNT_W-1:0]) state <= st_complete;
                end
                default: state <= st_idle; // complete lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (load) req_q <= req;
            end
            st_prepare: begin
                rem      <= '0;
                sign_q   <= dividend_neg ^ divisor_neg;
                sign_r   <= dividend_neg;
                quo      <= dividend_neg ? -req_q.dividend : req_q.dividend;
                den      <= divisor_neg ? -req_q.divisor : req_q.divisor;
                div_zero <= (req_q.divisor == '0);
                overflow <= is_signed && (req_q.dividend == min_neg) && (req_q.divisor == '1);
            end
            st_divide: begin
                // restoring step shifts the next dividend bit from quo into rem
                if (rem_shift >= {1'b0, den}) begin
                    rem <= rem_shift[`DIV_XLEN-1:0] - den;
                    quo <= {quo[`DIV_XLEN-2:0], 1'b1};
                end else begin
                    rem <= rem_shift[`DIV_XLEN-1:0];
                    quo <= {quo[`DIV_XLEN-2:0], 1'b0};
                end
            end
            default: ;
        endcase
    end

    assign quo_signed = sign_q ? -quo : quo;
    assign rem_signed = sign_r ? -rem : rem;

    always_comb begin
        if (div_zero) begin
            if ((req_q.op == div_pkg::op_div) || (req_q.op == div_pkg::op_divu)) begin
                result = '1;
            end else begin
                result = req_q.dividend;
            end
        end else if (overflow) begin
            result = (req_q.op == div_pkg::op_div) ? req_q.dividend : '0; // rem is zero
        end else begin
            case (req_q.op)
                div_pkg::op_div:  result = quo_signed;
                div_pkg::op_divu: result = quo;
                div_pkg::op_rem:  result = rem_signed;
                default:          result = rem;
            endcase
        end
    end

    assign rsp.result = result;
    assign rsp.tag    = req_q.tag;

endmodule

// File: design/div_pkg.sv
`include "div_settings.svh"

package div_pkg;

    // same encoding as the M-extension funct3 low bits
    typedef enum logic [1:0] {
        op_div  = 2'd0, // signed quotient
        op_divu = 2'd1,
        op_rem  = 2'd2, // signed remainder
        op_remu = 2'd3
    } div_op_t;

    typedef struct packed {
        div_op_t               op;
        logic [`DIV_XLEN-1:0]  dividend;
        logic [`DIV_XLEN-1:0]  divisor;
        logic [`DIV_TAG_W-1:0] tag;
    } div_req_t;

    typedef struct packed {
        logic [`DIV_XLEN-1:0]  result;
        logic [`DIV_TAG_W-1:0] tag; // copied from the request
    } div_rsp_t;

endpackage

// File: design/div_req_port.sv
`timescale 1ns/1ps

module div_req_port (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  div_pkg::div_req_t req,
    output logic              busy,
    output logic              done,
    output div_pkg::div_rsp_t rsp,
    output logic              pending,
    output div_pkg::div_req_t held_req,
    input  logic              grant,
    input  logic              complete,
    input  div_pkg::div_rsp_t complete_rsp
);

    logic accept;

    assign accept = start && !busy; // start while busy is dropped

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            pending <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= complete;
            if (accept) begin
                busy    <= 1'b1;
                pending <= 1'b1;
            end else begin
                if (grant) pending <= 1'b0;
                if (complete) busy <= 1'b0; // same edge that raises done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) held_req <= req;
        if (complete) rsp <= complete_rsp; // held until the next done
    end

endmodule

// File: design/div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

`define DIV_XLEN  32 // operand and result width
`define DIV_PORTS 2  // requester ports sharing the core
`define DIV_CNT_W 6  // wide enough for 32 steps
`define DIV_TAG_W 4  // client tag echoed in the response

`endif

// File: design/div_unit_top.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_unit_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`DIV_PORTS-1:0] start,
    input  div_pkg::div_req_t     req [`DIV_PORTS],
    output logic [`DIV_PORTS-1:0] busy,
    output logic [`DIV_PORTS-1:0] done,
    output div_pkg::div_rsp_t     rsp [`DIV_PORTS]
);

    logic [`DIV_PORTS-1:0] pending;
    logic [`DIV_PORTS-1:0] grant;
    logic [`DIV_PORTS-1:0] complete;
    div_pkg::div_req_t     held_req [`DIV_PORTS];
    div_pkg::div_rsp_t     complete_rsp; // shared, qualified by complete
    logic                  load;
    logic                  ready;
    logic                  finish;
    div_pkg::div_req_t     core_req;
    div_pkg::div_rsp_t     core_rsp;

    for (genvar p = 0; p < `DIV_PORTS; p++) begin : gen_port
        div_req_port u_port (
            .clk          (clk),
            .reset        (reset),
            .start        (start[p]),
            .req          (req[p]),
            .busy         (busy[p]),
            .done         (done[p]),
            .rsp          (rsp[p]),
            .pending      (pending[p]),
            .held_req     (held_req[p]),
            .grant        (grant[p]),
            .complete     (complete[p]),
            .complete_rsp (complete_rsp)
        );
    end

    div_arbiter u_arb (
        .clk          (clk),
        .reset        (reset),
        .pending      (pending),
        .held_req     (held_req),
        .grant        (grant),
        .ready        (ready),
        .load         (load),
        .core_req     (core_req),
        .finish       (finish),
        .core_rsp     (core_rsp),
        .complete     (complete),
        .complete_rsp (complete_rsp)
    );

    div_core u_core (
        .clk    (clk),
        .reset  (reset),
        .load   (load),
        .req    (core_req),
        .ready  (ready),
        .finish (finish),
        .rsp    (core_rsp)
    );

endmodule

// File: src.f
+incdir+design
+incdir+testbench
design/div_pkg.sv
design/div_core.sv
design/div_req_port.sv
design/div_arbiter.sv
design/div_unit_top.sv
testbench/tb_clock.sv
testbench/div_unit_tb.sv

// File: testbench/div_unit_vectors.svh
`ifndef DIV_UNIT_VECTORS_SVH
`define DIV_UNIT_VECTORS_SVH

// each entry holds port, request (op, dividend, divisor, tag) and expected result
// quotients truncate toward zero and remainders take the dividend's sign

localparam int num_vectors = 23;

vector_t vector_table [num_vectors] = '{
    // mixed signs
    '{1'b0, '{div_pkg::op_div,  32'h0000_0007, 32'hFFFF_FFFE, 4'h1}, 32'hFFFF_FFFD},
    '{1'b1, '{div_pkg::op_rem,  32'h0000_0007, 32'hFFFF_FFFE, 4'h2}, 32'h0000_0001},
    '{1'b0, '{div_pkg::op_div,  32'hFFFF_FFF9, 32'h0000_0002, 4'h3}, 32'hFFFF_FFFD},
    '{1'b1, '{div_pkg::op_rem,  32'hFFFF_FFF9, 32'h0000_0002, 4'h4}, 32'hFFFF_FFFF},
    '{1'b0, '{div_pkg::op_div,  32'hFFFF_FFF9, 32'hFFFF_FFFE, 4'h5}, 32'h0000_0003},
    '{1'b1, '{div_pkg::op_rem,  32'hFFFF_FFF9, 32'hFFFF_FFFE, 4'h6}, 32'hFFFF_FFFF},
    '{1'b0, '{div_pkg::op_rem,  32'h8000_0000, 32'h0000_0003, 4'h8}, 32'hFFFF_FFFE},
    // same bit patterns read as unsigned
    '{1'b0, '{div_pkg::op_divu, 32'hFFFF_FFF9, 32'h0000_0002, 4'h7}, 32'h7FFF_FFFC},
    '{1'b1, '{div_pkg::op_remu, 32'hFFFF_FFF9, 32'h0000_0002, 4'h8}, 32'h0000_0001},
    '{1'b0, '{div_pkg::op_divu, 32'h0000_0064, 32'h0000_0007, 4'h9}, 32'h0000_000E},
    '{1'b1, '{div_pkg::op_remu, 32'h0000_0064, 32'h0000_0007, 4'hA}, 32'h0000_0002},
    '{1'b0, '{div_pkg::op_div,  32'h1234_5678, 32'h0000_0100, 4'hB}, 32'h0012_3456},
    '{1'b1, '{div_pkg::op_rem,  32'h1234_5678, 32'h0000_0100, 4'hC}, 32'h0000_0078},
    '{1'b0, '{div_pkg::op_divu, 32'h8000_0000, 32'hFFFF_FFFF, 4'hD}, 32'h0000_0000},
    '{1'b1, '{div_pkg::op_remu, 32'h8000_0000, 32'hFFFF_FFFF, 4'hE}, 32'h8000_0000},
    // zero divisor
    '{1'b0, '{div_pkg::op_div,  32'h0000_1234, 32'h0000_0000, 4'h0}, 32'hFFFF_FFFF},
    '{1'b1, '{div_pkg::op_divu, 32'h0000_0005, 32'h0000_0000, 4'h1}, 32'hFFFF_FFFF},
    '{1'b0, '{div_pkg::op_rem,  32'hFFFF_FFF9, 32'h0000_0000, 4'h2}, 32'hFFFF_FFF9},
    '{1'b1, '{div_pkg::op_remu, 32'hDEAD_BEEF, 32'h0000_0000, 4'h3}, 32'hDEAD_BEEF},
    // signed overflow and its neighbours
    '{1'b0, '{div_pkg::op_div,  32'h8000_0000, 32'hFFFF_FFFF, 4'h4}, 32'h8000_0000},
    '{1'b1, '{div_pkg::op_rem,  32'h8000_0000, 32'hFFFF_FFFF, 4'h5}, 32'h0000_0000},
    '{1'b0, '{div_pkg::op_div,  32'h8000_0000, 32'h0000_0001, 4'h6}, 32'h8000_0000},
    '{1'b1, '{div_pkg::op_div,  32'h0000_0000, 32'hFFFF_FFFB, 4'h7}, 32'h0000_0000}
};

`endif

// File: testbench/div_unit_tb.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_unit_tb;

    typedef struct packed {
        logic                 port;
        div_pkg::div_req_t    req;
        logic [`DIV_XLEN-1:0] expected;
    } vector_t;

    `include "div_unit_vectors.svh"

    localparam int reset_cycles = 16;
    localparam int num_random   = 40;
    localparam int max_cycles   = (num_vectors + num_random) * 80 + reset_cycles;
    localparam logic [`DIV_XLEN-1:0] min_neg = {1'b1, {(`DIV_XLEN - 1){1'b0}}};

    logic                  clk;
    logic                  reset;
    logic [`DIV_PORTS-1:0] start;
    div_pkg::div_req_t     req [`DIV_PORTS];
    logic [`DIV_PORTS-1:0] busy;
    logic [`DIV_PORTS-1:0] done;
    div_pkg::div_rsp_t     rsp [`DIV_PORTS];
    int                    cycle_count = 0;

    tb_clock #(.reset_cycles(reset_cycles)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    div_unit_top u_dut (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .rsp   (rsp)
    );

    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rsp(string name, div_pkg::div_rsp_t got, div_pkg::div_rsp_t exp);
        if (got !== exp) begin
            $display("ERROR %s: result %h tag %h, expected result %h tag %h",
                     name, got.result, got.tag, exp.result, exp.tag);
            stop_on_error();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_latency(string name, int got, int exp);
        if (got != exp) begin
            $display("ERROR %s: got %h cycles, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // reference model on the language's truncating operators
    function automatic logic [`DIV_XLEN-1:0] expected_result(div_pkg::div_op_t op,
            logic [`DIV_XLEN-1:0] a, logic [`DIV_XLEN-1:0] b);
        logic signed [`DIV_XLEN-1:0] sa;
        logic signed [`DIV_XLEN-1:0] sb;
        logic                        overflow;
        sa = a;
        sb = b;
        overflow = (a == min_neg) && (b == '1);
        if (b == '0) begin
            if (op == div_pkg::op_div || op == div_pkg::op_divu) return '1;
            else return a;
        end
        case (op)
            div_pkg::op_div: begin
                if (overflow) return a;
                else return sa / sb;
            end
            div_pkg::op_rem: begin
                if (overflow) return '0;
                else return sa % sb;
            end
            div_pkg::op_divu: return a / b;
            default:          return a % b;
        endcase
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            stop_on_error();
        end
    end

    task automatic wait_idle(int port);
        @(negedge clk);
        while (busy[port]) @(negedge clk);
    endtask

    task automatic issue(int port, div_pkg::div_req_t r);
        @(posedge clk);
        start[port] <= 1'b1;
        req[port]   <= r;
        @(posedge clk);
        start[port] <= 1'b0;
    endtask

    // counts edges from the one after the start edge
    task automatic wait_done(int port, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done[port]);
        check_bit($sformatf("busy[%0d]", port), busy[port], 1'b0);
        @(negedge clk);
        check_bit($sformatf("done[%0d]", port), done[port], 1'b0); // single pulse
    endtask

    task automatic run_request(int port, div_pkg::div_req_t r, logic [`DIV_XLEN-1:0] expected);
        int                cycles;
        div_pkg::div_rsp_t exp_rsp;
        exp_rsp.result = expected;
        exp_rsp.tag    = r.tag;
        wait_idle(port);
        issue(port, r);
        wait_done(port, cycles);
        check_latency($sformatf("done[%0d] latency", port), cycles, 37);
        check_rsp($sformatf("rsp[%0d]", port), rsp[port], exp_rsp);
    endtask

    initial begin
        int unsigned       rnd;
        int                port;
        int                cycles;
        int                at0;
        int                at1;
        int                n;
        div_pkg::div_req_t r;
        div_pkg::div_req_t r0;
        div_pkg::div_req_t r1;
        div_pkg::div_rsp_t exp_rsp;

        void'($urandom(93546));
        start = '0;
        for (int p = 0; p < `DIV_PORTS; p++) req[p] = '0;

        @(negedge clk);
        while (reset) @(negedge clk);
        repeat (4) begin
            for (int p = 0; p < `DIV_PORTS; p++) begin
                check_bit($sformatf("busy[%0d]", p), busy[p], 1'b0);
                check_bit($sformatf("done[%0d]", p), done[p], 1'b0);
            end
            @(negedge clk);
        end

        // both ports start in the same cycle while the pointer is on port 0
        r0 = '{div_pkg::op_div, 32'hFFFF_FF9C, 32'h0000_0007, 4'h3};
        r1 = '{div_pkg::op_remu, 32'hDEAD_BEEF, 32'h0000_1234, 4'h9};
        @(posedge clk);
        start  <= '1;
        req[0] <= r0;
        req[1] <= r1;
        @(posedge clk);
        start <= '0;
        at0 = 0;
        at1 = 0;
        n   = 0;
        while (at0 == 0 || at1 == 0) begin
            @(negedge clk);
            n++;
            if (done[0] && at0 == 0) begin
                at0 = n;
                exp_rsp = '{expected_result(r0.op, r0.dividend, r0.divisor), r0.tag};
                check_rsp("rsp[0]", rsp[0], exp_rsp);
            end
            if (done[1] && at1 == 0) begin
                at1 = n;
                exp_rsp = '{expected_result(r1.op, r1.dividend, r1.divisor), r1.tag};
                check_rsp("rsp[1]", rsp[1], exp_rsp);
            end
        end
        if (at0 >= at1) begin
            $display("port 0 did not finish before port 1 (done at %0d and %0d)", at0, at1);
            stop_on_error();
        end

        // uncontended latency
        r = '{div_pkg::op_divu, 32'h0000_03E8, 32'h0000_0003, 4'h5};
        wait_idle(0);
        issue(0, r);
        wait_done(0, cycles);
        check_latency("done[0] latency", cycles, 37);
        check_rsp("rsp[0]", rsp[0], '{32'h0000_014D, 4'h5});

        for (int i = 0; i < num_vectors; i++) begin
            run_request(int'(vector_table[i].port), vector_table[i].req,
                        vector_table[i].expected);
        end

        // second start while busy must be dropped
        r0 = '{div_pkg::op_rem, 32'hFFFF_FF00, 32'h0000_0007, 4'hA};
        r1 = '{div_pkg::op_divu, 32'h0000_0010, 32'h0000_0002, 4'h6};
        wait_idle(0);
        issue(0, r0);
        @(negedge clk);
        check_bit("busy[0]", busy[0], 1'b1);
        issue(0, r1);
        wait_done(0, cycles);
        exp_rsp = '{expected_result(r0.op, r0.dividend, r0.divisor), r0.tag};
        check_rsp("rsp[0]", rsp[0], exp_rsp);
        repeat (45) begin
            @(negedge clk);
            check_bit("done[0]", done[0], 1'b0);
            check_bit("busy[0]", busy[0], 1'b0);
        end

        for (int i = 0; i < num_random; i++) begin
            rnd = $urandom;
            port = int'(rnd[0]);
            r.op  = div_pkg::div_op_t'(rnd[2:1]);
            r.tag = rnd[6:3];
            r.dividend = (rnd[9:7] == 3'd0) ? min_neg : $urandom;
            case (rnd[12:10])
                3'd0:    r.divisor = '0;
                3'd1:    r.divisor = '1;
                3'd2:    r.divisor = {{(`DIV_XLEN - 4){1'b0}}, rnd[16:13]} + 1'b1;
                default: r.divisor = $urandom;
            endcase
            run_request(port, r, expected_result(r.op, r.dividend, r.divisor));
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule
